// File: build.f
rtl/wro_pkg.sv
rtl/wro_tag_heap.sv
rtl/wro_addr_filter.sv
rtl/wro_issue_ctrl.sv
rtl/wro_rsp_restore.sv
rtl/wro_shim.sv
tests/wro_props.sv
tests/wro_tb.sv

// File: Makefile
# Verilator build and run for the write-ordering shim testbench

VERILATOR  ?= verilator
TOP        ?= wro_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= TEST FAILED
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/wro_tb.sv
/* Directed testbench for the write-ordering shim. The testbench plays the memory
   and answers a request only when a test asks for it. */

`timescale 1ns/10ps

module wro_tb;

    logic          clk;
    logic          reset;
    wro_pkg::t_req req;
    logic          req_ready;
    wro_pkg::t_req mem_req;
    logic          mem_ready;
    wro_pkg::t_rsp mem_rsp;
    wro_pkg::t_rsp rsp;

    int            seed;
    int            err_count;
    int            check_count;

    // Memory handshakes and requester responses in arrival order
    wro_pkg::t_req mem_seen [$];
    wro_pkg::t_rsp rsp_seen [$];

    wro_shim u_wro_shim (
        .clk, .reset, .req, .req_ready, .mem_req, .mem_ready, .mem_rsp, .rsp
    );

    always #2 clk = ~clk;

    // Monitors record on the rising edge, tests look at the queues on the falling edge
    always @(posedge clk)
    begin
        if (!reset && mem_req.valid && mem_ready)
            mem_seen.push_back(mem_req);
        if (!reset && rsp.valid)
            rsp_seen.push_back(rsp);
    end

    // ========================================
    // Compare tasks
    // ========================================

    task automatic check_req(input string name, input wro_pkg::t_req got,
                             input wro_pkg::t_req exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rsp(input string name, input wro_pkg::t_rsp got,
                             input wro_pkg::t_rsp exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ========================================
    // Request and response helpers
    // ========================================

    // Writes carry random data, and every request gets random mdata
    function automatic wro_pkg::t_req make_req(input logic is_write,
                                               input logic [31:0] addr);
        wro_pkg::t_req r;
        r.valid    = 1'b1;
        r.is_write = is_write;
        r.addr     = addr;
        r.data     = is_write ? $random(seed) : 32'h0;
        r.mdata    = 16'($random(seed));
        return r;
    endfunction

    // The tag sits in the low mdata bits, 3 for writes and 4 for reads
    function automatic int tag_of(input wro_pkg::t_req m);
        if (m.is_write)
            return int'(m.mdata[wro_pkg::WR_TAG_BITS-1:0]);
        return int'(m.mdata[wro_pkg::RD_TAG_BITS-1:0]);
    endfunction

    function automatic wro_pkg::t_req with_tag(input wro_pkg::t_req r, input int tag);
        wro_pkg::t_req e;
        e = r;
        if (r.is_write)
            e.mdata[wro_pkg::WR_TAG_BITS-1:0] = wro_pkg::t_wr_tag'(tag);
        else
            e.mdata[wro_pkg::RD_TAG_BITS-1:0] = wro_pkg::t_rd_tag'(tag);
        return e;
    endfunction

    // Hold the request until the shim takes it
    task automatic send_req(input wro_pkg::t_req r);
        int waited;
        waited = 0;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        while (!req_ready && waited < 100)
        begin
            @(posedge clk);
            waited++;
        end
        if (!req_ready)
        begin
            err_count++;
            $display("Request to addr %h was never accepted", r.addr);
        end
        req.valid <= 1'b0;
    endtask

    // Pops the next memory handshake and checks everything but the tag
    task automatic expect_mem_req(input wro_pkg::t_req r, input int max_cycles,
                                  output wro_pkg::t_req got);
        int waited;
        waited = 0;
        got = '0;
        while (mem_seen.size() == 0 && waited < max_cycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (mem_seen.size() == 0)
        begin
            err_count++;
            $display("No memory request for addr %h within %0d cycles", r.addr, max_cycles);
        end
        else
        begin
            got = mem_seen.pop_front();
            check_req("mem_req", got, with_tag(r, tag_of(got)));
        end
    endtask

    // A blocked request must not reach memory during the window
    task automatic expect_no_mem_req(input int cycles);
        repeat (cycles) @(negedge clk);
        check_count++;
        if (mem_seen.size() != 0)
        begin
            err_count++;
            $display("Memory request to addr %h was issued while it should wait",
                     mem_seen[0].addr);
        end
    endtask

    // One-cycle response pulse from memory, echoing the tagged mdata
    task automatic send_mem_rsp(input wro_pkg::t_req issued, input logic [31:0] data);
        wro_pkg::t_rsp r;
        r.valid    = 1'b1;
        r.is_write = issued.is_write;
        r.data     = data;
        r.mdata    = issued.mdata;
        @(posedge clk);
        mem_rsp <= r;
        @(posedge clk);
        mem_rsp.valid <= 1'b0;
    endtask

    // Memory answers with random data and the requester must see its own mdata
    task automatic return_rsp(input wro_pkg::t_req issued, input wro_pkg::t_req orig);
        wro_pkg::t_rsp exp;
        logic [31:0]   data;
        int            waited;
        data         = $random(seed);
        exp.valid    = 1'b1;
        exp.is_write = orig.is_write;
        exp.data     = data;
        exp.mdata    = orig.mdata;
        waited       = 0;
        send_mem_rsp(issued, data);
        while (rsp_seen.size() == 0 && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        if (rsp_seen.size() == 0)
        begin
            err_count++;
            $display("No response reached the requester for addr %h", orig.addr);
        end
        else
            check_rsp("rsp", rsp_seen.pop_front(), exp);
    endtask

    task automatic report_test(input string name, input int start);
        $display("%s: %0d errors", name, err_count - start);
    endtask

    // ========================================
    // Directed tests
    // ========================================

    // Addresses below 512 fold to themselves, so distinct ones never collide
    task automatic test_independent();
        wro_pkg::t_req rd;
        wro_pkg::t_req wr;
        wro_pkg::t_req rd_m;
        wro_pkg::t_req wr_m;
        int            start;
        start = err_count;
        rd = make_req(1'b0, 32'h0000_0010);
        wr = make_req(1'b1, 32'h0000_0024);
        send_req(rd);
        expect_mem_req(rd, 20, rd_m);
        send_req(wr);
        expect_mem_req(wr, 20, wr_m);
        // Answer in reverse order
        return_rsp(wr_m, wr);
        return_rsp(rd_m, rd);
        report_test("independent addresses", start);
    endtask

    task automatic test_write_after_write();
        wro_pkg::t_req w1;
        wro_pkg::t_req w2;
        wro_pkg::t_req w1_m;
        wro_pkg::t_req w2_m;
        int            start;
        start = err_count;
        w1 = make_req(1'b1, 32'h0000_0080);
        w2 = make_req(1'b1, 32'h0000_0080);
        send_req(w1);
        expect_mem_req(w1, 20, w1_m);
        send_req(w2);
        expect_no_mem_req(20);
        return_rsp(w1_m, w1);
        expect_mem_req(w2, 20, w2_m);
        return_rsp(w2_m, w2);
        report_test("write after write", start);
    endtask

    task automatic test_read_against_write();
        wro_pkg::t_req w;
        wro_pkg::t_req r1;
        wro_pkg::t_req r2;
        wro_pkg::t_req w_m;
        wro_pkg::t_req r1_m;
        wro_pkg::t_req r2_m;
        int            start;
        start = err_count;
        w  = make_req(1'b1, 32'h0000_0044);
        r1 = make_req(1'b0, 32'h0000_0044);
        r2 = make_req(1'b0, 32'h0000_0044);
        send_req(w);
        expect_mem_req(w, 20, w_m);
        send_req(r1);
        expect_no_mem_req(20);
        return_rsp(w_m, w);
        expect_mem_req(r1, 20, r1_m);
        // Reads share an address freely, so the handshake is due two cycles later
        send_req(r2);
        expect_mem_req(r2, 4, r2_m);
        return_rsp(r2_m, r2);
        return_rsp(r1_m, r1);
        report_test("read against write", start);
    endtask

    task automatic test_backpressure();
        wro_pkg::t_req r;
        wro_pkg::t_req held;
        wro_pkg::t_req r_m;
        int            waited;
        int            start;
        start  = err_count;
        waited = 0;
        r      = make_req(1'b0, 32'h0000_00c0);
        @(posedge clk);
        mem_ready <= 1'b0;
        send_req(r);
        while (!mem_req.valid && waited < 20)
        begin
            @(negedge clk);
            waited++;
        end
        held = mem_req;
        check_bit("mem_req.valid", mem_req.valid, 1'b1);
        check_req("mem_req", held, with_tag(r, tag_of(held)));
        repeat (10)
        begin
            @(negedge clk);
            check_req("mem_req", mem_req, held);
            check_bit("req_ready", req_ready, 1'b0);
        end
        @(posedge clk);
        mem_ready <= 1'b1;
        expect_mem_req(r, 20, r_m);
        check_req("mem_req", r_m, held);
        expect_no_mem_req(10);
        check_bit("req_ready", req_ready, 1'b1);
        return_rsp(r_m, r);
        report_test("back-pressure", start);
    endtask

    task automatic test_tag_exhaustion();
        wro_pkg::t_req w   [9];
        wro_pkg::t_req w_m [9];
        int            start;
        start = err_count;
        for (int i = 0; i < 9; i++)
            w[i] = make_req(1'b1, 32'h0000_0100 + 32'(4 * i));
        for (int i = 0; i < 8; i++)
        begin
            send_req(w[i]);
            expect_mem_req(w[i], 20, w_m[i]);
        end
        // All eight write tags are out, so the ninth has to wait
        send_req(w[8]);
        expect_no_mem_req(20);
        return_rsp(w_m[3], w[3]);
        // The freed tag is the only one left, so it must be reused
        expect_mem_req(w[8], 20, w_m[8]);
        check_req("mem_req", w_m[8], with_tag(w[8], tag_of(w_m[3])));
        for (int i = 0; i < 9; i++)
        begin
            if (i != 3)
                return_rsp(w_m[i], w[i]);
        end
        report_test("tag exhaustion", start);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        seed        = 67204;
        err_count   = 0;
        check_count = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        req         = '0;
        mem_ready   = 1'b1;
        mem_rsp     = '0;

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        test_independent();
        test_write_after_write();
        test_read_against_write();
        test_backpressure();
        test_tag_exhaustion();

        repeat (5) @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Last line of defense if a wait loop is ever left without a bound
    initial
    begin
        #100000;
        $display("Simulation hit the watchdog before all tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tests/wro_props.sv
/* Port-level timing checks for the shim, bound onto every wro_shim instance. */

`timescale 1ns/10ps

module wro_props (
    input logic          clk,
    input logic          reset,
    input logic          req_ready,
    input wro_pkg::t_req mem_req,
    input logic          mem_ready,
    input wro_pkg::t_rsp mem_rsp,
    input wro_pkg::t_rsp rsp
);

    // A stalled memory request keeps its whole payload until memory takes it
    mem_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req.valid && !mem_ready |=> mem_req.valid && $stable(mem_req))
        else $error("mem_req changed while waiting for mem_ready");

    // Nothing is offered in the cycle after a reset cycle
    quiet_after_reset: assert property (@(posedge clk)
        reset |=> !req_ready && !mem_req.valid && !rsp.valid)
        else $error("Control outputs not low after reset");

    // The response path is a single register stage
    rsp_one_cycle: assert property (@(posedge clk) disable iff (reset)
        rsp.valid == $past(mem_rsp.valid))
        else $error("rsp.valid does not follow mem_rsp.valid by one cycle");

endmodule

bind wro_shim wro_props u_wro_props (
    .clk, .reset, .req_ready, .mem_req, .mem_ready, .mem_rsp, .rsp
);

// File: rtl/wro_shim.sv
/* Write-ordering shim between a requester and an out-of-order memory port.
   One request is tested at a time while many may be outstanding at memory. */

`timescale 1ns/10ps

module wro_shim (
    input  logic          clk,
    input  logic          reset,
    input  wro_pkg::t_req req,
    output logic          req_ready,
    output wro_pkg::t_req mem_req,
    input  logic          mem_ready,
    input  wro_pkg::t_rsp mem_rsp,
    output wro_pkg::t_rsp rsp
);

    logic               rd_hit;
    logic               wr_hit;
    logic               rd_not_full;
    logic               wr_not_full;
    logic               rd_alloc;
    logic               wr_alloc;
    logic               rd_free;
    logic               wr_free;
    wro_pkg::t_hash     cur_hash;
    wro_pkg::t_rd_tag   rd_alloc_tag;
    wro_pkg::t_wr_tag   wr_alloc_tag;
    wro_pkg::t_rd_tag   rd_free_tag;
    wro_pkg::t_wr_tag   wr_free_tag;
    wro_pkg::t_rd_saved rd_saved_req;
    wro_pkg::t_wr_saved wr_saved_req;
    wro_pkg::t_rd_saved rd_saved_rsp;
    wro_pkg::t_wr_saved wr_saved_rsp;

    // ========================================
    // Request side
    // ========================================

    wro_issue_ctrl u_issue_ctrl (
        .clk, .reset, .req, .req_ready, .mem_req, .mem_ready,
        .rd_hit, .wr_hit, .rd_not_full, .wr_not_full,
        .rd_tag(rd_alloc_tag), .wr_tag(wr_alloc_tag), .cur_hash,
        .rd_alloc, .wr_alloc, .rd_saved(rd_saved_req), .wr_saved(wr_saved_req)
    );

    // Each filter slot shares its index with the heap tag of the same kind
    wro_addr_filter #(.N_ENTRIES(wro_pkg::N_RD_TAGS)) u_rd_filter (
        .clk, .reset, .test_hash(cur_hash), .test_hit(rd_hit),
        .insert_en(rd_alloc), .insert_tag(rd_alloc_tag), .insert_hash(cur_hash),
        .remove_en(rd_free), .remove_tag(rd_free_tag)
    );

    wro_addr_filter #(.N_ENTRIES(wro_pkg::N_WR_TAGS)) u_wr_filter (
        .clk, .reset, .test_hash(cur_hash), .test_hit(wr_hit),
        .insert_en(wr_alloc), .insert_tag(wr_alloc_tag), .insert_hash(cur_hash),
        .remove_en(wr_free), .remove_tag(wr_free_tag)
    );

    // ========================================
    // Tag heaps and response side
    // ========================================

    wro_tag_heap #(.t_payload(wro_pkg::t_rd_saved), .N_ENTRIES(wro_pkg::N_RD_TAGS)) u_rd_heap (
        .clk, .reset, .alloc(rd_alloc), .alloc_data(rd_saved_req),
        .alloc_tag(rd_alloc_tag), .not_full(rd_not_full),
        .read_tag(rd_free_tag), .read_data(rd_saved_rsp),
        .free(rd_free), .free_tag(rd_free_tag)
    );

    wro_tag_heap #(.t_payload(wro_pkg::t_wr_saved), .N_ENTRIES(wro_pkg::N_WR_TAGS)) u_wr_heap (
        .clk, .reset, .alloc(wr_alloc), .alloc_data(wr_saved_req),
        .alloc_tag(wr_alloc_tag), .not_full(wr_not_full),
        .read_tag(wr_free_tag), .read_data(wr_saved_rsp),
        .free(wr_free), .free_tag(wr_free_tag)
    );

    wro_rsp_restore u_rsp_restore (
        .clk, .reset, .mem_rsp, .rd_free, .wr_free, .rd_free_tag, .wr_free_tag,
        .rd_saved(rd_saved_rsp), .wr_saved(wr_saved_rsp), .rsp
    );

endmodule

// File: rtl/wro_rsp_restore.sv
/* Responses carry their tag in the low mdata bits. The tag is freed on arrival
   and the requester sees the response one cycle later. */

`timescale 1ns/10ps

module wro_rsp_restore (
    input  logic                clk,
    input  logic                reset,
    input  wro_pkg::t_rsp       mem_rsp,
    output logic                rd_free,
    output logic                wr_free,
    output wro_pkg::t_rd_tag    rd_free_tag,
    output wro_pkg::t_wr_tag    wr_free_tag,
    input  wro_pkg::t_rd_saved  rd_saved,
    input  wro_pkg::t_wr_saved  wr_saved,
    output wro_pkg::t_rsp       rsp
);

    wro_pkg::t_rsp rsp_q;

    // Freeing in the arrival cycle clears the filter before the next test
    assign rd_free     = mem_rsp.valid && !mem_rsp.is_write;
    assign wr_free     = mem_rsp.valid && mem_rsp.is_write;
    assign rd_free_tag = mem_rsp.mdata[wro_pkg::RD_TAG_BITS-1:0];
    assign wr_free_tag = mem_rsp.mdata[wro_pkg::WR_TAG_BITS-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_q.valid <= 1'b0;
        else
            rsp_q.valid <= mem_rsp.valid;
    end

    always_ff @(posedge clk)
    begin
        rsp_q.is_write <= mem_rsp.is_write;
        rsp_q.data     <= mem_rsp.data;
        rsp_q.mdata    <= mem_rsp.mdata;
    end

    // Heap read data lines up with the registered response
    always_comb
    begin
        rsp = rsp_q;
        if (rsp_q.is_write)
            rsp.mdata[wro_pkg::WR_TAG_BITS-1:0] = wr_saved;
        else
            rsp.mdata[wro_pkg::RD_TAG_BITS-1:0] = rd_saved;
    end

endmodule

// File: rtl/wro_issue_ctrl.sv
/* Handles one request at a time. A request waits in issue only while clear of
   conflict with a tag on offer, so mem_req stays put until memory takes it. */

`timescale 1ns/10ps

module wro_issue_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  wro_pkg::t_req       req,
    output logic                req_ready,
    output wro_pkg::t_req       mem_req,
    input  logic                mem_ready,
    input  logic                rd_hit,
    input  logic                wr_hit,
    input  logic                rd_not_full,
    input  logic                wr_not_full,
    input  wro_pkg::t_rd_tag    rd_tag,
    input  wro_pkg::t_wr_tag    wr_tag,
    output wro_pkg::t_hash      cur_hash,
    output logic                rd_alloc,
    output logic                wr_alloc,
    output wro_pkg::t_rd_saved  rd_saved,
    output wro_pkg::t_wr_saved  wr_saved
);

    typedef enum logic [1:0] {ST_IDLE, ST_TEST, ST_ISSUE} t_state;

    t_state         state;
    t_state         state_next;
    wro_pkg::t_req  req_q;
    wro_pkg::t_hash hash_q;
    logic           conflict_q;
    logic           heap_ok;
    logic           issue_ok;
    logic           mem_fire;

    // ========================================
    // Issue decision
    // ========================================

    // Heap space for the kind of request being held
    assign heap_ok  = req_q.is_write ? wr_not_full : rd_not_full;
    assign issue_ok = (state == ST_ISSUE) && !conflict_q && heap_ok;
    assign mem_fire = issue_ok && mem_ready;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
                if (req.valid && req_ready)
                    state_next = ST_TEST;
            ST_TEST:
                state_next = ST_ISSUE;
            ST_ISSUE:
                // A blocked request goes back and tests the filters again
                if (!issue_ok)
                    state_next = ST_TEST;
                else if (mem_ready)
                    state_next = ST_IDLE;
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_IDLE;
            req_ready  <= 1'b0;
            conflict_q <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // Ready is a flop so it comes up one cycle after reset drops
            req_ready <= (state_next == ST_IDLE);
            // Reads only collide with writes but writes collide with both
            if (state == ST_TEST)
                conflict_q <= req_q.is_write ? (rd_hit || wr_hit) : wr_hit;
        end
    end

    // Request payload and its hash are captured on acceptance
    always_ff @(posedge clk)
    begin
        if (req.valid && req_ready)
        begin
            req_q  <= req;
            hash_q <= wro_pkg::wro_hash(req.addr);
        end
    end

    // ========================================
    // Memory request and tag allocation
    // ========================================

    // The tag replaces the low mdata bits of the outgoing request
    always_comb
    begin
        mem_req       = req_q;
        mem_req.valid = issue_ok;
        if (req_q.is_write)
            mem_req.mdata[wro_pkg::WR_TAG_BITS-1:0] = wr_tag;
        else
            mem_req.mdata[wro_pkg::RD_TAG_BITS-1:0] = rd_tag;
    end

    assign cur_hash = hash_q;
    assign rd_alloc = mem_fire && !req_q.is_write;
    assign wr_alloc = mem_fire && req_q.is_write;

    // Mdata bits displaced by the tag go into the heap
    assign rd_saved = req_q.mdata[wro_pkg::RD_TAG_BITS-1:0];
    assign wr_saved = req_q.mdata[wro_pkg::WR_TAG_BITS-1:0];

endmodule

// File: rtl/wro_addr_filter.sv
/* Hash store indexed by tag. Several entries may hold the same hash, and a
   collision only produces a false hit. */

`timescale 1ns/10ps

module wro_addr_filter #(
    parameter int N_ENTRIES = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  wro_pkg::t_hash               test_hash,
    output logic                         test_hit,
    input  logic                         insert_en,
    input  logic [$clog2(N_ENTRIES)-1:0] insert_tag,
    input  wro_pkg::t_hash               insert_hash,
    input  logic                         remove_en,
    input  logic [$clog2(N_ENTRIES)-1:0] remove_tag
);

    // ========================================
    // Entry state
    // ========================================

    // Valid bits mark outstanding requests
    logic [N_ENTRIES-1:0] entry_valid;

    // Hashes only matter while the entry is valid
    wro_pkg::t_hash       entry_hash [N_ENTRIES];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            entry_valid <= '0;
        end
        else
        begin
            // Insert and remove always name different tags since the heap
            // never hands out a tag that is still in flight
            if (remove_en)
                entry_valid[remove_tag] <= 1'b0;
            if (insert_en)
                entry_valid[insert_tag] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (insert_en)
            entry_hash[insert_tag] <= insert_hash;
    end

    // ========================================
    // Presence test
    // ========================================

    // Compare the test hash against every live entry
    always_comb
    begin
        test_hit = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            if (entry_valid[i] && (entry_hash[i] == test_hash))
                test_hit = 1'b1;
        end
    end

endmodule

// File: rtl/wro_tag_heap.sv
/* Tag heap with one payload word per tag. alloc_tag only moves on alloc or
   while the heap is full, so a caller may present it across several cycles. */

`timescale 1ns/10ps

module wro_tag_heap #(
    parameter type t_payload = logic,
    parameter int  N_ENTRIES = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         alloc,
    input  t_payload                     alloc_data,
    output logic [$clog2(N_ENTRIES)-1:0] alloc_tag,
    output logic                         not_full,
    input  logic [$clog2(N_ENTRIES)-1:0] read_tag,
    output t_payload                     read_data,
    input  logic                         free,
    input  logic [$clog2(N_ENTRIES)-1:0] free_tag
);

    typedef logic [$clog2(N_ENTRIES)-1:0]   t_tag;
    typedef logic [$clog2(N_ENTRIES+1)-1:0] t_count;

    // One bit per entry, set while the entry is available
    logic [N_ENTRIES-1:0] free_vec;
    logic [N_ENTRIES-1:0] free_vec_next;
    t_count               free_count;
    t_tag                 lowest_free;

    // Payload storage has no reset since entries are always written before use
    t_payload             storage [N_ENTRIES];

    // Project the free vector one cycle ahead and pick its lowest set bit
    always_comb
    begin
        free_vec_next = free_vec;
        if (alloc)
            free_vec_next[alloc_tag] = 1'b0;
        if (free)
            free_vec_next[free_tag] = 1'b1;

        lowest_free = '0;
        for (int i = N_ENTRIES - 1; i >= 0; i--)
        begin
            if (free_vec_next[i])
                lowest_free = t_tag'(i);
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_vec   <= '1;
            free_count <= t_count'(N_ENTRIES);
            alloc_tag  <= '0;
        end
        else
        begin
            free_vec <= free_vec_next;

            // Alloc and free in the same cycle leave the count unchanged
            case ({alloc, free})
                2'b10:   free_count <= free_count - 1'b1;
                2'b01:   free_count <= free_count + 1'b1;
                default: free_count <= free_count;
            endcase

            // Hold the offered tag steady until it is taken
            if (alloc || (free_count == '0))
                alloc_tag <= lowest_free;
        end
    end

    assign not_full = (free_count != '0);

    // Storage written on alloc and read one cycle after the request
    always_ff @(posedge clk)
    begin
        if (alloc)
            storage[alloc_tag] <= alloc_data;
        read_data <= storage[read_tag];
    end

endmodule

// File: rtl/wro_pkg.sv
/* Shared widths, tag counts and payload types for the write-ordering shim.
   Tag widths must stay below MDATA_BITS since tags overwrite the low mdata bits. */

package wro_pkg;

    // ========================================
    // Widths and tag counts
    // ========================================

    localparam int ADDR_BITS  = 32;
    localparam int DATA_BITS  = 32;
    localparam int MDATA_BITS = 16;
    localparam int HASH_BITS  = 9;

    // Reads usually need more slots in flight than writes
    localparam int N_RD_TAGS   = 16;
    localparam int N_WR_TAGS   = 8;
    localparam int RD_TAG_BITS = $clog2(N_RD_TAGS);
    localparam int WR_TAG_BITS = $clog2(N_WR_TAGS);

    // Number of hash slices needed to cover the whole address
    localparam int HASH_SLICES = (ADDR_BITS + HASH_BITS - 1) / HASH_BITS;

    typedef logic [HASH_BITS-1:0]   t_hash;
    typedef logic [RD_TAG_BITS-1:0] t_rd_tag;
    typedef logic [WR_TAG_BITS-1:0] t_wr_tag;

    // Mdata bits that a tag overwrites are parked in the heap as these types
    typedef logic [RD_TAG_BITS-1:0] t_rd_saved;
    typedef logic [WR_TAG_BITS-1:0] t_wr_saved;

    typedef struct packed
    {
        logic                  valid;
        logic                  is_write;
        logic [ADDR_BITS-1:0]  addr;
        logic [DATA_BITS-1:0]  data;
        logic [MDATA_BITS-1:0] mdata;
    } t_req;

    // Memory responses and requester responses share this layout
    typedef struct packed
    {
        logic                  valid;
        logic                  is_write;
        logic [DATA_BITS-1:0]  data;
        logic [MDATA_BITS-1:0] mdata;
    } t_rsp;

    // XOR-fold the address into HASH_BITS slices starting at bit 0
    // The top slice is only partly filled and gets zero-extended
    function automatic t_hash wro_hash(input logic [ADDR_BITS-1:0] addr);
        logic [HASH_SLICES*HASH_BITS-1:0] padded;
        t_hash                            h;
        padded = {{(HASH_SLICES*HASH_BITS-ADDR_BITS){1'b0}}, addr};
        h = '0;
        for (int i = 0; i < HASH_SLICES; i++)
        begin
            h = h ^ padded[i*HASH_BITS +: HASH_BITS];
        end
        return h;
    endfunction

endpackage
